// File: ci_bus_pkg.sv
package ci_bus_pkg;

    // Bus and memory sizes
    localparam int DATA_W    = 32;
    localparam int MEM_AW    = 8;           // Word address into the shared memory
    localparam int MEM_WORDS = 256;

    // Host port word addressing
    localparam int HOST_AW     = 12;
    localparam int MEM_SEL_BIT = 11;        // Set for the memory window

    // Register map below the memory window
    localparam logic [MEM_SEL_BIT-1:0] REG_CTRL   = 11'd0;  // Bit 0 run
    localparam logic [MEM_SEL_BIT-1:0] REG_STATUS = 11'd1;  // Bit 0 halted
    localparam logic [MEM_SEL_BIT-1:0] REG_CYCLES = 11'd2;  // Cycles spent running

endpackage

// File: ci_core_pkg.sv
package ci_core_pkg;

    // Instruction word layout
    // opcode in the top nibble, immediate or address in the low half
    localparam int OPC_MSB = 31;
    localparam int OPC_LSB = 28;
    localparam int IMM_W   = 16;

    typedef enum logic [3:0] {
        OP_LOADI = 4'h1,    // acc = imm
        OP_LOAD  = 4'h2,    // acc = mem[addr]
        OP_STORE = 4'h3,    // mem[addr] = acc
        OP_ADD   = 4'h4,    // acc += mem[addr]
        OP_SUB   = 4'h5,    // acc -= mem[addr]
        OP_JNZ   = 4'h6,    // pc = addr if acc != 0
        OP_HALT  = 4'hF
    } opcode_e;

    // Core sequencing
    typedef enum logic [1:0] {
        ST_FETCH  = 2'd0,
        ST_DECODE = 2'd1,
        ST_MEM    = 2'd2,   // Data access for load, add, sub, store
        ST_HALT   = 2'd3
    } core_state_e;

endpackage

// File: ci_wb_if.sv
`timescale 1ns/100ps

interface ci_wb_if;

    logic                          cyc;
    logic                          stb;
    logic                          we;
    logic [ci_bus_pkg::MEM_AW-1:0] adr;     // Word address
    logic [ci_bus_pkg::DATA_W-1:0] dat_m2s; // Write data
    logic [ci_bus_pkg::DATA_W-1:0] dat_s2m; // Read data, valid with ack
    logic                          ack;

    modport master (
        output cyc, stb, we, adr, dat_m2s,
        input  dat_s2m, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_m2s,
        output dat_s2m, ack
    );

endinterface

// File: ci_memory.sv
`timescale 1ns/100ps

module ci_memory (
    input  logic   sys_clk_i,
    input  logic   rst_n_i,
    ci_wb_if.slave load_bus,    // Port A, host window
    ci_wb_if.slave fetch_bus    // Port B, core
);

    logic [ci_bus_pkg::DATA_W-1:0] mem_q [ci_bus_pkg::MEM_WORDS];
    logic [ci_bus_pkg::DATA_W-1:0] rdata_a_q;
    logic [ci_bus_pkg::DATA_W-1:0] rdata_b_q;
    logic                          ack_a_q;
    logic                          ack_b_q;
    logic                          req_a;
    logic                          req_b;

    // A strobe counts as new only when it is not being acked this cycle
    assign req_a = load_bus.cyc & load_bus.stb & ~ack_a_q;
    assign req_b = fetch_bus.cyc & fetch_bus.stb & ~ack_b_q;

    always_ff @(posedge sys_clk_i) begin
        if (!rst_n_i) begin
            ack_a_q <= 1'b0;
            ack_b_q <= 1'b0;
        end else begin
            ack_a_q <= req_a;   // One-cycle ack pulse
            ack_b_q <= req_b;
        end
    end

    // Port B goes first so port A lands last on a same-word collision
    always_ff @(posedge sys_clk_i) begin
        if (req_b && fetch_bus.we) begin
            mem_q[fetch_bus.adr] <= fetch_bus.dat_m2s;
        end
        if (req_a && load_bus.we) begin
            mem_q[load_bus.adr] <= load_bus.dat_m2s;
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (req_a) begin
            rdata_a_q <= mem_q[load_bus.adr];
        end
        if (req_b) begin
            rdata_b_q <= mem_q[fetch_bus.adr];
        end
    end

    assign load_bus.ack      = ack_a_q;
    assign load_bus.dat_s2m  = rdata_a_q;
    assign fetch_bus.ack     = ack_b_q;
    assign fetch_bus.dat_s2m = rdata_b_q;

endmodule

// File: ci_ctrl_regs.sv
`timescale 1ns/100ps

module ci_ctrl_regs (
    input  logic                           sys_clk_i,
    input  logic                           rst_n_i,
    input  logic                           host_cyc_i,
    input  logic                           host_stb_i,
    input  logic                           host_we_i,
    input  logic [ci_bus_pkg::HOST_AW-1:0] host_adr_i,
    input  logic [ci_bus_pkg::DATA_W-1:0]  host_dat_i,
    output logic [ci_bus_pkg::DATA_W-1:0]  host_dat_o,
    output logic                           host_ack_o,
    ci_wb_if.master                        load_bus,
    output logic                           core_run_o,
    input  logic                           core_halted_i
);

    logic                               host_req;
    logic                               mem_sel;
    logic [ci_bus_pkg::MEM_SEL_BIT-1:0] reg_adr;
    logic                               reg_req;
    logic                               reg_wr;
    logic                               run_start;
    logic                               reg_ack_q;
    logic [ci_bus_pkg::DATA_W-1:0]      reg_rdata_q;
    logic                               run_q;
    logic [ci_bus_pkg::DATA_W-1:0]      cycles_q;
    logic                               lb_stb_q;
    logic                               lb_we_q;
    logic [ci_bus_pkg::MEM_AW-1:0]      lb_adr_q;
    logic [ci_bus_pkg::DATA_W-1:0]      lb_dat_q;

    assign host_req = host_cyc_i & host_stb_i;
    assign mem_sel  = host_adr_i[ci_bus_pkg::MEM_SEL_BIT];
    assign reg_adr  = host_adr_i[ci_bus_pkg::MEM_SEL_BIT-1:0];

    // Register side answers each strobe once
    assign reg_req   = host_req & ~mem_sel & ~reg_ack_q;
    assign reg_wr    = reg_req & host_we_i;
    assign run_start = reg_wr & (reg_adr == ci_bus_pkg::REG_CTRL) & host_dat_i[0] & ~run_q;

    always_ff @(posedge sys_clk_i) begin
        if (!rst_n_i) begin
            reg_ack_q <= 1'b0;
            run_q     <= 1'b0;
            cycles_q  <= '0;
            lb_stb_q  <= 1'b0;
        end else begin
            reg_ack_q <= reg_req;
            if (reg_wr && reg_adr == ci_bus_pkg::REG_CTRL) begin
                run_q <= host_dat_i[0];
            end
            if (run_start) begin
                cycles_q <= '0;             // Fresh count for each run
            end else if (run_q && !core_halted_i) begin
                cycles_q <= cycles_q + 1'b1;
            end
            // Memory window, held on load_bus until the memory acks
            if (lb_stb_q) begin
                lb_stb_q <= ~load_bus.ack;
            end else if (host_req && mem_sel) begin
                lb_stb_q <= 1'b1;
            end
        end
    end

    // Snapshot of the addressed register at the strobe
    always_ff @(posedge sys_clk_i) begin
        if (reg_req) begin
            case (reg_adr)
                ci_bus_pkg::REG_CTRL:   reg_rdata_q <= {{(ci_bus_pkg::DATA_W-1){1'b0}}, run_q};
                ci_bus_pkg::REG_STATUS: reg_rdata_q <= {{(ci_bus_pkg::DATA_W-1){1'b0}}, core_halted_i};
                ci_bus_pkg::REG_CYCLES: reg_rdata_q <= cycles_q;
                default:                reg_rdata_q <= '0;
            endcase
        end
        if (!lb_stb_q) begin
            lb_we_q  <= host_we_i;
            lb_adr_q <= host_adr_i[ci_bus_pkg::MEM_AW-1:0];
            lb_dat_q <= host_dat_i;
        end
    end

    assign load_bus.cyc     = lb_stb_q;
    assign load_bus.stb     = lb_stb_q;
    assign load_bus.we      = lb_we_q;
    assign load_bus.adr     = lb_adr_q;
    assign load_bus.dat_m2s = lb_dat_q;

    // Host sees the memory ack directly in the window
    assign host_ack_o = mem_sel ? load_bus.ack : reg_ack_q;
    assign host_dat_o = mem_sel ? load_bus.dat_s2m : reg_rdata_q;

    assign core_run_o = run_q;

endmodule

// File: ci_core.sv
`timescale 1ns/100ps

module ci_core (
    input  logic    sys_clk_i,
    input  logic    rst_n_i,
    input  logic    core_run_i,
    ci_wb_if.master fetch_bus,
    output logic    core_halted_o
);

    ci_core_pkg::core_state_e          state_q;
    logic [ci_bus_pkg::MEM_AW-1:0]     pc_q;
    logic [ci_bus_pkg::DATA_W-1:0]     acc_q;
    logic [ci_bus_pkg::DATA_W-1:0]     ir_q;
    ci_core_pkg::opcode_e              opcode;
    logic [ci_core_pkg::IMM_W-1:0]     field;
    logic [ci_bus_pkg::MEM_AW-1:0]     op_adr;
    logic [ci_bus_pkg::DATA_W-1:0]     imm_ext;
    logic                              fetching;
    logic                              data_access;

    // Instruction fields
    assign opcode  = ci_core_pkg::opcode_e'(ir_q[ci_core_pkg::OPC_MSB:ci_core_pkg::OPC_LSB]);
    assign field   = ir_q[ci_core_pkg::IMM_W-1:0];
    assign op_adr  = field[ci_bus_pkg::MEM_AW-1:0];
    assign imm_ext = {{(ci_bus_pkg::DATA_W-ci_core_pkg::IMM_W){1'b0}}, field};

    assign fetching    = core_run_i && state_q == ci_core_pkg::ST_FETCH;
    assign data_access = core_run_i && state_q == ci_core_pkg::ST_MEM;

    always_ff @(posedge sys_clk_i) begin
        if (!rst_n_i || !core_run_i) begin
            // Parked at pc 0 until run is set
            state_q <= ci_core_pkg::ST_FETCH;
            pc_q    <= '0;
            acc_q   <= '0;
        end else begin
            case (state_q)
                ci_core_pkg::ST_FETCH: begin
                    if (fetch_bus.ack) begin
                        state_q <= ci_core_pkg::ST_DECODE;
                    end
                end

                ci_core_pkg::ST_DECODE: begin
                    case (opcode)
                        ci_core_pkg::OP_LOADI: begin
                            acc_q   <= imm_ext;
                            pc_q    <= pc_q + 1'b1;
                            state_q <= ci_core_pkg::ST_FETCH;
                        end
                        ci_core_pkg::OP_JNZ: begin
                            pc_q    <= (acc_q != '0) ? op_adr : pc_q + 1'b1;
                            state_q <= ci_core_pkg::ST_FETCH;
                        end
                        ci_core_pkg::OP_LOAD,
                        ci_core_pkg::OP_STORE,
                        ci_core_pkg::OP_ADD,
                        ci_core_pkg::OP_SUB: begin
                            state_q <= ci_core_pkg::ST_MEM;
                        end
                        default: begin
                            state_q <= ci_core_pkg::ST_HALT;   // HALT and unknown codes
                        end
                    endcase
                end

                ci_core_pkg::ST_MEM: begin
                    if (fetch_bus.ack) begin
                        case (opcode)
                            ci_core_pkg::OP_LOAD: acc_q <= fetch_bus.dat_s2m;
                            ci_core_pkg::OP_ADD:  acc_q <= acc_q + fetch_bus.dat_s2m;
                            ci_core_pkg::OP_SUB:  acc_q <= acc_q - fetch_bus.dat_s2m;
                            default:              acc_q <= acc_q;  // Store leaves acc alone
                        endcase
                        pc_q    <= pc_q + 1'b1;     // Wraps at the top of memory
                        state_q <= ci_core_pkg::ST_FETCH;
                    end
                end

                default: begin
                    state_q <= ci_core_pkg::ST_HALT;    // Stays until run drops
                end
            endcase
        end
    end

    // Instruction word, captured on the fetch ack
    always_ff @(posedge sys_clk_i) begin
        if (fetching && fetch_bus.ack) begin
            ir_q <= fetch_bus.dat_s2m;
        end
    end

    // Bus requests follow the state directly
    assign fetch_bus.cyc     = fetching | data_access;
    assign fetch_bus.stb     = fetching | data_access;
    assign fetch_bus.we      = data_access && opcode == ci_core_pkg::OP_STORE;
    assign fetch_bus.adr     = data_access ? op_adr : pc_q;
    assign fetch_bus.dat_m2s = acc_q;

    assign core_halted_o = (state_q == ci_core_pkg::ST_HALT);

endmodule

// File: processorci_top.sv
`timescale 1ns/100ps

module processorci_top (
    input  logic                           sys_clk_i,
    input  logic                           rst_n_i,

    // Host Wishbone slave port
    input  logic                           host_cyc_i,
    input  logic                           host_stb_i,
    input  logic                           host_we_i,
    input  logic [ci_bus_pkg::HOST_AW-1:0] host_adr_i,
    input  logic [ci_bus_pkg::DATA_W-1:0]  host_dat_i,
    output logic [ci_bus_pkg::DATA_W-1:0]  host_dat_o,
    output logic                           host_ack_o
);

    logic core_run;
    logic core_halted;

    ci_wb_if load_bus ();   // Register block to memory port A
    ci_wb_if fetch_bus ();  // Core to memory port B

    ci_ctrl_regs ci_ctrl_regs_i (
        .sys_clk_i     (sys_clk_i),
        .rst_n_i       (rst_n_i),
        .host_cyc_i    (host_cyc_i),
        .host_stb_i    (host_stb_i),
        .host_we_i     (host_we_i),
        .host_adr_i    (host_adr_i),
        .host_dat_i    (host_dat_i),
        .host_dat_o    (host_dat_o),
        .host_ack_o    (host_ack_o),
        .load_bus      (load_bus.master),
        .core_run_o    (core_run),
        .core_halted_i (core_halted)
    );

    // Core space
    ci_core ci_core_i (
        .sys_clk_i     (sys_clk_i),
        .rst_n_i       (rst_n_i),
        .core_run_i    (core_run),
        .fetch_bus     (fetch_bus.master),
        .core_halted_o (core_halted)
    );

    ci_memory ci_memory_i (
        .sys_clk_i (sys_clk_i),
        .rst_n_i   (rst_n_i),
        .load_bus  (load_bus.slave),
        .fetch_bus (fetch_bus.slave)
    );

endmodule

// File: tb_processorci.sv
`timescale 1ns/100ps

module tb_processorci;

    localparam int MAX_LINES    = 64;
    localparam int POLL_TRIES   = 200;  // Status reads before a poll gives up
    localparam int CYC_PER_LINE = 200;

    logic                           sys_clk = 1'b0;
    logic                           rst_n;
    logic                           host_cyc;
    logic                           host_stb;
    logic                           host_we;
    logic [ci_bus_pkg::HOST_AW-1:0] host_adr;
    logic [ci_bus_pkg::DATA_W-1:0]  host_dat_w;
    logic [ci_bus_pkg::DATA_W-1:0]  host_dat_r;
    logic                           host_ack;

    // One entry per stimulus line
    logic [8*24-1:0]                st_name  [MAX_LINES];
    logic [7:0]                     st_op    [MAX_LINES];
    logic [ci_bus_pkg::HOST_AW-1:0] st_adr   [MAX_LINES];
    logic [ci_bus_pkg::DATA_W-1:0]  st_wdata [MAX_LINES];
    logic [ci_bus_pkg::DATA_W-1:0]  st_exp   [MAX_LINES];

    int n_lines     = 0;
    int n_pass      = 0;
    int n_fail      = 0;
    int test_errs   = 0;
    int cycle_cnt   = 0;
    int cycle_limit = 0;    // Zero until the stimulus is loaded

    processorci_top processorci_top_i (
        .sys_clk_i  (sys_clk),
        .rst_n_i    (rst_n),
        .host_cyc_i (host_cyc),
        .host_stb_i (host_stb),
        .host_we_i  (host_we),
        .host_adr_i (host_adr),
        .host_dat_i (host_dat_w),
        .host_dat_o (host_dat_r),
        .host_ack_o (host_ack)
    );

    always #50 sys_clk = ~sys_clk;     // 100 ns period

    always @(posedge sys_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic load_stimulus(output logic ok);
        int                            fd;
        int                            cnt;
        string                         line;
        logic [8*24-1:0]               name;
        logic [7:0]                    op;
        logic [31:0]                   adr;
        logic [ci_bus_pkg::DATA_W-1:0] wd;
        logic [ci_bus_pkg::DATA_W-1:0] ex;
        ok = 1'b0;
        fd = $fopen("processorci_stimulus.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                cnt = $fgets(line, fd);
                // Comment lines start with a hash
                if (cnt > 0 && line[0] != "#" && n_lines < MAX_LINES) begin
                    cnt = $sscanf(line, "%s %s %h %h %h", name, op, adr, wd, ex);
                    if (cnt == 5) begin
                        st_name[n_lines]  = name;
                        st_op[n_lines]    = op;
                        st_adr[n_lines]   = adr[ci_bus_pkg::HOST_AW-1:0];
                        st_wdata[n_lines] = wd;
                        st_exp[n_lines]   = ex;
                        n_lines++;
                    end
                end
            end
            $fclose(fd);
            ok = (n_lines > 0);
        end
    endtask

    // One Wishbone classic access on the host port
    task automatic host_access(input logic we, input logic [ci_bus_pkg::HOST_AW-1:0] adr,
                               input logic [ci_bus_pkg::DATA_W-1:0] wdata,
                               output logic [ci_bus_pkg::DATA_W-1:0] rdata);
        @(posedge sys_clk);
        #1;
        host_cyc   = 1'b1;
        host_stb   = 1'b1;
        host_we    = we;
        host_adr   = adr;
        host_dat_w = wdata;
        @(negedge sys_clk);
        while (!host_ack) begin
            @(negedge sys_clk);
        end
        rdata = host_dat_r;     // Valid in the ack cycle
        @(posedge sys_clk);
        #1;
        host_cyc = 1'b0;
        host_stb = 1'b0;
        host_we  = 1'b0;
    endtask

    task automatic run_line(input int idx);
        logic [ci_bus_pkg::DATA_W-1:0] rdata;
        int                            tries;
        case (st_op[idx])
            "W": host_access(1'b1, st_adr[idx], st_wdata[idx], rdata);
            "R": begin
                host_access(1'b0, st_adr[idx], '0, rdata);
                assert (rdata === st_exp[idx]) else begin
                    $display("Error: %0s expected %08h actual %08h",
                             st_name[idx], st_exp[idx], rdata);
                    test_errs++;
                end
            end
            "P": begin
                tries = 0;
                rdata = ~st_exp[idx];
                while (rdata !== st_exp[idx] && tries < POLL_TRIES) begin
                    host_access(1'b0, st_adr[idx], '0, rdata);
                    tries++;
                end
                assert (rdata === st_exp[idx]) else begin
                    $display("%0s: the core never reported halted after %0d status reads",
                             st_name[idx], tries);
                    test_errs++;
                end
            end
            default: begin
                $display("%0s: unknown operation in the stimulus file", st_name[idx]);
                test_errs++;
            end
        endcase
    endtask

    task automatic close_test(input logic [8*24-1:0] name);
        if (test_errs == 0) begin
            n_pass++;
            $display("Test %0s passed", name);
        end else begin
            n_fail++;
            $display("Test %0s failed with %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    initial begin
        logic ok;
        rst_n      = 1'b0;
        host_cyc   = 1'b0;
        host_stb   = 1'b0;
        host_we    = 1'b0;
        host_adr   = '0;
        host_dat_w = '0;
        load_stimulus(ok);
        if (!ok) begin
            $display("Could not read any line from processorci_stimulus.txt");
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            cycle_limit = n_lines * CYC_PER_LINE;
            repeat (16) @(posedge sys_clk);
            #1 rst_n = 1'b1;
            // Consecutive lines with the same name form one test
            for (int i = 0; i < n_lines; i++) begin
                if (i > 0 && st_name[i] != st_name[i-1]) begin
                    close_test(st_name[i-1]);
                end
                run_line(i);
            end
            close_test(st_name[n_lines-1]);
            $display("Tests: %0d passed, %0d failed", n_pass, n_fail);
            if (n_fail == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

// File: processorci_stimulus.txt
# name op host_adr wdata expected, hex; op W write, R read and compare, P poll until equal
# Host addresses 800 to 8ff are the memory window, lower ones are registers
ctrl_regs   W 000 00000000 00000000
ctrl_regs   R 000 00000000 00000000
ctrl_regs   W 001 00000001 00000000
ctrl_regs   R 001 00000000 00000000
ctrl_regs   W 003 00001234 00000000
ctrl_regs   R 003 00000000 00000000
mem_window  W 8ff a5a5f00f 00000000
mem_window  W 880 12345678 00000000
mem_window  W 801 deadbeef 00000000
mem_window  R 8ff 00000000 a5a5f00f
mem_window  R 880 00000000 12345678
mem_window  R 801 00000000 deadbeef
load_prog   W 800 10000005 00000000
load_prog   W 801 30000040 00000000
load_prog   W 802 20000040 00000000
load_prog   W 803 40000041 00000000
load_prog   W 804 30000041 00000000
load_prog   W 805 20000040 00000000
load_prog   W 806 50000042 00000000
load_prog   W 807 30000040 00000000
load_prog   W 808 60000002 00000000
load_prog   W 809 f0000000 00000000
load_prog   W 841 00000000 00000000
load_prog   W 842 00000001 00000000
load_prog   R 803 00000000 40000041
run_sum     W 000 00000001 00000000
run_sum     R 000 00000000 00000001
run_sum     P 001 00000000 00000001
run_sum     R 841 00000000 0000000f
cycles_hold R 002 00000000 000000b0
cycles_hold R 002 00000000 000000b0
restart     W 000 00000000 00000000
restart     R 001 00000000 00000000
restart     W 800 10000003 00000000
restart     W 841 00000000 00000000
restart     W 000 00000001 00000000
restart     P 001 00000000 00000001
restart     R 841 00000000 00000006
restart     R 002 00000000 0000006e

// File: vlog.f
ci_bus_pkg.sv
ci_core_pkg.sv
ci_wb_if.sv
ci_memory.sv
ci_ctrl_regs.sv
ci_core.sv
processorci_top.sv
tb_processorci.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds tb_processorci with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_processorci -Mdir obj_dir -f vlog.f \
    && ./obj_dir/Vtb_processorci > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0
